/* verilog/lsu_pkg.sv */
//************************************************
// LSU control package
// Widths, access sizes, region map and fault cause
// codes shared by the load/store control path
//************************************************
package lsu_pkg;

   // Vector types with a meaning
   typedef logic [31:0] addr_t;       // Byte address
   typedef logic [31:0] data_t;       // Register data
   typedef logic [11:0] offset_t;     // Immediate offset
   typedef logic [63:0] dma_data_t;   // DMA write data
   typedef logic [3:0]  mscause_t;    // Fault cause code
   typedef logic [1:0]  size_t;       // Access size code

   //************************************************
   // Access sizes
   //************************************************
   localparam size_t SIZE_BYTE = 2'd0;
   localparam size_t SIZE_HALF = 2'd1;
   localparam size_t SIZE_WORD = 2'd2;

   // Region map
   localparam addr_t DCCM_BASE = 32'hF004_0000;
   localparam addr_t DCCM_SIZE = 32'h0001_0000;   // 64 KB
   localparam addr_t PIC_BASE  = 32'hF00C_0000;
   localparam addr_t PIC_SIZE  = 32'h0000_8000;   // 32 KB

   // Fault cause codes
   localparam mscause_t MSCAUSE_NONE         = 4'd0;
   localparam mscause_t MSCAUSE_ECC          = 4'd1;
   localparam mscause_t MSCAUSE_REGION_CROSS = 4'd2;
   localparam mscause_t MSCAUSE_PIC_SIZE     = 4'd3;
   localparam mscause_t MSCAUSE_MISALIGNED   = 4'd4;

   //************************************************
   // Packets
   //************************************************
   typedef struct packed {
      logic  valid;
      logic  load;
      logic  store;
      logic  unsign;
      size_t size;
      logic  dma;
   } lsu_pkt_t;

   typedef struct packed {
      logic     in_dccm;
      logic     in_pic;
      logic     external;
      logic     misaligned;
      logic     access_fault;
      mscause_t mscause;
   } addr_chk_t;

   // Offset from first to last byte of an access
   function automatic addr_t access_len_m1(size_t size);
      case (size)
         SIZE_HALF: return 32'd1;
         SIZE_WORD: return 32'd3;
         default:   return 32'd0;
      endcase
   endfunction

endpackage

/* verilog/lsu_req_if.sv */
//************************************************
// LSU request interface
// One D-stage access from a requester
//************************************************
`timescale 1ns/1ps

interface lsu_req_if;
   import lsu_pkg::*;

   logic     valid;        // Level, one cycle per access
   lsu_pkt_t pkt;
   addr_t    start_addr;
   addr_t    end_addr;     // Last byte of the access
   data_t    store_data;

   modport src (
      output valid, pkt, start_addr, end_addr, store_data
   );

   modport dst (
      input valid, pkt, start_addr, end_addr, store_data
   );

endinterface

/* verilog/lsu_core_req.sv */
//************************************************
// Core requester
// Forms start/end address from rs1 and offset
//************************************************
`timescale 1ns/1ps

module lsu_core_req (
   input  logic               dec_lsu_valid_raw_d,
   input  logic               lsu_load,
   input  logic               lsu_store,
   input  logic               lsu_unsign,
   input  lsu_pkg::size_t     lsu_size,
   input  lsu_pkg::addr_t     exu_lsu_rs1_d,
   input  lsu_pkg::offset_t   dec_lsu_offset_d,
   input  lsu_pkg::data_t     exu_lsu_rs2_d,
   input  logic               flush_m_up,
   lsu_req_if.src             req
);
   import lsu_pkg::*;

   addr_t offset_ext;
   addr_t start_addr;

   assign offset_ext = {{20{dec_lsu_offset_d[11]}}, dec_lsu_offset_d};
   assign start_addr = exu_lsu_rs1_d + offset_ext;

   // Raw valid wins arbitration even when the access is flushed
   assign req.valid      = dec_lsu_valid_raw_d;
   assign req.start_addr = start_addr;
   assign req.end_addr   = start_addr + access_len_m1(lsu_size);
   assign req.store_data = exu_lsu_rs2_d;

   always_comb begin
      req.pkt        = '0;
      req.pkt.valid  = dec_lsu_valid_raw_d & ~flush_m_up;
      req.pkt.load   = lsu_load;
      req.pkt.store  = lsu_store;
      req.pkt.unsign = lsu_unsign;
      req.pkt.size   = lsu_size;
      req.pkt.dma    = 1'b0;
   end

endmodule

/* verilog/lsu_dma_req.sv */
//************************************************
// DMA requester
// Builds the access packet and shifts write data
// down to byte lane 0
//************************************************
`timescale 1ns/1ps

module lsu_dma_req (
   input  logic                 dma_dccm_req,
   input  logic                 dma_mem_write,
   input  lsu_pkg::size_t       dma_mem_sz,
   input  lsu_pkg::addr_t       dma_mem_addr,
   input  lsu_pkg::dma_data_t   dma_mem_wdata,
   lsu_req_if.src               req
);
   import lsu_pkg::*;

   dma_data_t wdata_shifted;

   // Align to the byte addressed within the dword
   assign wdata_shifted = dma_mem_wdata >> {dma_mem_addr[2:0], 3'b000};

   assign req.valid      = dma_dccm_req;
   assign req.start_addr = dma_mem_addr;
   assign req.end_addr   = dma_mem_addr + access_len_m1(dma_mem_sz);
   assign req.store_data = wdata_shifted[31:0];   // Low word only

   always_comb begin
      req.pkt        = '0;
      req.pkt.valid  = dma_dccm_req;
      req.pkt.load   = ~dma_mem_write;
      req.pkt.store  = dma_mem_write;
      req.pkt.unsign = 1'b0;
      req.pkt.size   = dma_mem_sz;
      req.pkt.dma    = 1'b1;
   end

endmodule

/* verilog/lsu_req_arbiter.sv */
//************************************************
// Request arbiter
// Fixed priority, core ahead of DMA
//************************************************
`timescale 1ns/1ps

module lsu_req_arbiter (
   lsu_req_if.dst   core,
   lsu_req_if.dst   dma,
   lsu_req_if.src   sel
);

   // A DMA request in a core cycle is lost
   always_comb begin
      if (core.valid) begin
         sel.valid      = 1'b1;
         sel.pkt        = core.pkt;
         sel.start_addr = core.start_addr;
         sel.end_addr   = core.end_addr;
         sel.store_data = core.store_data;
      end else begin
         sel.valid      = dma.valid;
         sel.pkt        = dma.pkt;
         sel.start_addr = dma.start_addr;
         sel.end_addr   = dma.end_addr;
         sel.store_data = dma.store_data;
      end
   end

endmodule

/* verilog/lsu_addr_check.sv */
//************************************************
// Address check
// Region decode and misaligned/access faults in D
//************************************************
`timescale 1ns/1ps

module lsu_addr_check (
   lsu_req_if.dst               req,
   output lsu_pkg::addr_chk_t   chk
);
   import lsu_pkg::*;

   logic  start_dccm, start_pic;
   logic  end_dccm, end_pic;
   logic  misaligned;
   logic  region_cross;
   logic  pic_size_err;
   addr_t len_m1;

   function automatic logic in_region(addr_t addr, addr_t base, addr_t size);
      return (addr - base) < size;   // Wraps above for addresses below base
   endfunction

   assign start_dccm = in_region(req.start_addr, DCCM_BASE, DCCM_SIZE);
   assign start_pic  = in_region(req.start_addr, PIC_BASE, PIC_SIZE);
   assign end_dccm   = in_region(req.end_addr, DCCM_BASE, DCCM_SIZE);
   assign end_pic    = in_region(req.end_addr, PIC_BASE, PIC_SIZE);

   assign len_m1 = access_len_m1(req.pkt.size);

   //************************************************
   // Faults
   //************************************************
   assign misaligned   = ((req.start_addr[1:0] & len_m1[1:0]) != 2'b00) & ~start_dccm;
   assign region_cross = (start_dccm != end_dccm) | (start_pic != end_pic);
   assign pic_size_err = start_pic & (req.pkt.size != SIZE_WORD);  // PIC is word only

   always_comb begin
      chk              = '0;
      chk.in_dccm      = start_dccm;
      chk.in_pic       = start_pic;
      chk.external     = ~start_dccm & ~start_pic;
      chk.misaligned   = misaligned;
      chk.access_fault = ~misaligned & (region_cross | pic_size_err);
      if (misaligned)
         chk.mscause = MSCAUSE_MISALIGNED;
      else if (region_cross)
         chk.mscause = MSCAUSE_REGION_CROSS;
      else if (pic_size_err)
         chk.mscause = MSCAUSE_PIC_SIZE;
      else
         chk.mscause = MSCAUSE_NONE;
   end

endmodule

/* verilog/lsu_pipe.sv */
//************************************************
// LSU pipeline D -> M -> R
// Packet, address, faults and ECC flags down the
// pipe; error packet and commit at R
//************************************************
`timescale 1ns/1ps

module lsu_pipe (
   input  logic                 clk,
   input  logic                 arst_n,
   lsu_req_if.dst               req,
   input  lsu_pkg::addr_chk_t   chk,
   input  logic                 flush_m_up,
   input  logic                 flush_r,
   input  logic                 lsu_single_ecc_error_m,
   input  logic                 lsu_double_ecc_error_m,
   output lsu_pkg::lsu_pkt_t    pkt_m,
   output lsu_pkg::addr_t       lsu_addr_m,
   output lsu_pkg::addr_t       lsu_addr_r,
   output logic                 addr_in_dccm_m,
   output logic                 addr_in_pic_m,
   output logic                 addr_external_m,
   output lsu_pkg::data_t       store_data_m,
   output logic                 lsu_exc_m,
   output logic                 lsu_commit_r,
   output logic                 lsu_single_ecc_error_incr,
   output logic                 lsu_error_valid_r,
   output logic                 lsu_error_type_r,
   output logic                 lsu_error_store_r,
   output lsu_pkg::mscause_t    lsu_error_mscause_r,
   output lsu_pkg::addr_t       lsu_error_addr_r
);
   import lsu_pkg::*;

   logic      valid_m_in, valid_r_in;
   logic      valid_m, valid_r;
   lsu_pkt_t  pkt_m_q, pkt_r_q, pkt_r;
   addr_chk_t chk_m;
   logic      misaligned_r, access_fault_r;
   mscause_t  mscause_r;
   logic      single_ecc_r, double_ecc_r;

   // Flush drops core accesses only
   assign valid_m_in = req.pkt.valid & ~(flush_m_up & ~req.pkt.dma);
   assign valid_r_in = valid_m & ~(flush_m_up & ~pkt_m_q.dma);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_m <= 1'b0;
         valid_r <= 1'b0;
      end else begin
         valid_m <= valid_m_in;
         valid_r <= valid_r_in;
      end
   end

   //************************************************
   // Payload registers
   //************************************************
   always_ff @(posedge clk) begin
      pkt_m_q        <= req.pkt;
      lsu_addr_m     <= req.start_addr;
      chk_m          <= chk;
      store_data_m   <= req.store_data;
      pkt_r_q        <= pkt_m_q;
      lsu_addr_r     <= lsu_addr_m;
      misaligned_r   <= chk_m.misaligned;
      access_fault_r <= chk_m.access_fault;
      mscause_r      <= chk_m.mscause;
      single_ecc_r   <= lsu_single_ecc_error_m;
      double_ecc_r   <= lsu_double_ecc_error_m;
   end

   always_comb begin
      pkt_m       = pkt_m_q;
      pkt_m.valid = valid_m;
      pkt_r       = pkt_r_q;
      pkt_r.valid = valid_r;
   end

   // M-stage outputs
   assign addr_in_dccm_m  = chk_m.in_dccm;
   assign addr_in_pic_m   = chk_m.in_pic;
   assign addr_external_m = chk_m.external;
   assign lsu_exc_m       = valid_m & (chk_m.misaligned | chk_m.access_fault);

   //************************************************
   // R stage
   //************************************************
   assign lsu_error_valid_r = (misaligned_r | access_fault_r | double_ecc_r)
                              & pkt_r.valid & ~pkt_r.dma;
   assign lsu_error_type_r  = ~misaligned_r;   // 0 misaligned, 1 access
   assign lsu_error_store_r = pkt_r.store;
   assign lsu_error_addr_r  = lsu_addr_r;

   // ECC cause only when no address fault is present
   assign lsu_error_mscause_r = (double_ecc_r & ~misaligned_r & ~access_fault_r) ?
                                MSCAUSE_ECC : mscause_r;

   assign lsu_commit_r = pkt_r.valid & (pkt_r.load | pkt_r.store) & ~pkt_r.dma & ~flush_r;

   assign lsu_single_ecc_error_incr = single_ecc_r & ~double_ecc_r
                                      & (lsu_commit_r | pkt_r.dma) & pkt_r.valid;

endmodule

/* verilog/lsu_load_align.sv */
//************************************************
// Load align
// M-stage data select and sign/zero extension
//************************************************
`timescale 1ns/1ps

module lsu_load_align (
   input  lsu_pkg::lsu_pkt_t   pkt_m,
   input  logic                addr_external_m,
   input  lsu_pkg::data_t      lsu_ld_data_m,
   input  lsu_pkg::data_t      bus_read_data_m,
   output lsu_pkg::data_t      lsu_result_m
);
   import lsu_pkg::*;

   data_t ld_data_fn;

   assign ld_data_fn = addr_external_m ? bus_read_data_m : lsu_ld_data_m;

   // Data already sits at bit 0
   always_comb begin
      case (pkt_m.size)
         SIZE_BYTE: lsu_result_m = pkt_m.unsign ? {24'b0, ld_data_fn[7:0]}
                                               : {{24{ld_data_fn[7]}}, ld_data_fn[7:0]};
         SIZE_HALF: lsu_result_m = pkt_m.unsign ? {16'b0, ld_data_fn[15:0]}
                                               : {{16{ld_data_fn[15]}}, ld_data_fn[15:0]};
         default:   lsu_result_m = ld_data_fn;   // Word
      endcase
   end

endmodule

/* verilog/lsu_ctl_top.sv */
//************************************************
// LSU control top
// Core and DMA requesters, arbiter and pipeline
//************************************************
`timescale 1ns/1ps

module lsu_ctl_top (
   input  logic                 clk,
   input  logic                 arst_n,

   // Core request
   input  logic                 dec_lsu_valid_raw_d,
   input  logic                 lsu_load,
   input  logic                 lsu_store,
   input  logic                 lsu_unsign,
   input  lsu_pkg::size_t       lsu_size,
   input  lsu_pkg::addr_t       exu_lsu_rs1_d,
   input  lsu_pkg::offset_t     dec_lsu_offset_d,
   input  lsu_pkg::data_t       exu_lsu_rs2_d,

   // DMA slave
   input  logic                 dma_dccm_req,
   input  logic                 dma_mem_write,
   input  lsu_pkg::size_t       dma_mem_sz,
   input  lsu_pkg::addr_t       dma_mem_addr,
   input  lsu_pkg::dma_data_t   dma_mem_wdata,

   input  logic                 flush_m_up,
   input  logic                 flush_r,
   input  logic                 lsu_single_ecc_error_m,
   input  logic                 lsu_double_ecc_error_m,
   input  lsu_pkg::data_t       lsu_ld_data_m,
   input  lsu_pkg::data_t       bus_read_data_m,

   output lsu_pkg::addr_t       lsu_addr_m,
   output lsu_pkg::addr_t       lsu_addr_r,
   output logic                 addr_in_dccm_m,
   output logic                 addr_in_pic_m,
   output logic                 addr_external_m,
   output lsu_pkg::data_t       store_data_m,
   output logic                 lsu_exc_m,
   output logic                 lsu_commit_r,
   output logic                 lsu_single_ecc_error_incr,
   output logic                 lsu_error_valid_r,
   output logic                 lsu_error_type_r,
   output logic                 lsu_error_store_r,
   output lsu_pkg::mscause_t    lsu_error_mscause_r,
   output lsu_pkg::addr_t       lsu_error_addr_r,
   output lsu_pkg::data_t       lsu_result_m
);
   import lsu_pkg::*;

   lsu_pkt_t  pkt_m;
   addr_chk_t chk;

   lsu_req_if core_req ();
   lsu_req_if dma_req ();
   lsu_req_if sel_req ();

   lsu_core_req lsu_core_req_i (
      .dec_lsu_valid_raw_d, .lsu_load, .lsu_store, .lsu_unsign, .lsu_size,
      .exu_lsu_rs1_d, .dec_lsu_offset_d, .exu_lsu_rs2_d, .flush_m_up,
      .req (core_req)
   );

   lsu_dma_req lsu_dma_req_i (
      .dma_dccm_req, .dma_mem_write, .dma_mem_sz, .dma_mem_addr, .dma_mem_wdata,
      .req (dma_req)
   );

   lsu_req_arbiter lsu_req_arbiter_i (.core (core_req), .dma (dma_req), .sel (sel_req));

   lsu_addr_check lsu_addr_check_i (.req (sel_req), .chk (chk));

   lsu_pipe lsu_pipe_i (
      .clk, .arst_n, .req (sel_req), .chk, .flush_m_up, .flush_r,
      .lsu_single_ecc_error_m, .lsu_double_ecc_error_m, .pkt_m,
      .lsu_addr_m, .lsu_addr_r, .addr_in_dccm_m, .addr_in_pic_m, .addr_external_m,
      .store_data_m, .lsu_exc_m, .lsu_commit_r, .lsu_single_ecc_error_incr,
      .lsu_error_valid_r, .lsu_error_type_r, .lsu_error_store_r,
      .lsu_error_mscause_r, .lsu_error_addr_r
   );

   lsu_load_align lsu_load_align_i (
      .pkt_m, .addr_external_m, .lsu_ld_data_m, .bus_read_data_m, .lsu_result_m
   );

endmodule

/* testbench/lsu_checker.sv */
//************************************************
// LSU checker
// Reference D/M/R model compared against the DUT
// ports on every rising clock edge
//************************************************
`timescale 1ns/1ps

module lsu_checker (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 dec_lsu_valid_raw_d, lsu_load, lsu_store, lsu_unsign,
   input  lsu_pkg::size_t       lsu_size,
   input  lsu_pkg::addr_t       exu_lsu_rs1_d,
   input  lsu_pkg::offset_t     dec_lsu_offset_d,
   input  lsu_pkg::data_t       exu_lsu_rs2_d,
   input  logic                 dma_dccm_req, dma_mem_write,
   input  lsu_pkg::size_t       dma_mem_sz,
   input  lsu_pkg::addr_t       dma_mem_addr,
   input  lsu_pkg::dma_data_t   dma_mem_wdata,
   input  logic                 flush_m_up, flush_r,
   input  logic                 lsu_single_ecc_error_m, lsu_double_ecc_error_m,
   input  lsu_pkg::data_t       lsu_ld_data_m, bus_read_data_m,
   input  lsu_pkg::addr_t       lsu_addr_m, lsu_addr_r,
   input  logic                 addr_in_dccm_m, addr_in_pic_m, addr_external_m,
   input  lsu_pkg::data_t       store_data_m, lsu_result_m,
   input  logic                 lsu_exc_m, lsu_commit_r, lsu_single_ecc_error_incr,
   input  logic                 lsu_error_valid_r, lsu_error_type_r, lsu_error_store_r,
   input  lsu_pkg::mscause_t    lsu_error_mscause_r,
   input  lsu_pkg::addr_t       lsu_error_addr_r,
   input  int                   test_num,
   input  logic                 test_end,
   output int                   checks_total,
   output int                   errors_total
);
   import lsu_pkg::*;

   typedef struct packed {
      logic     valid, dma, load, store, unsign;
      size_t    size;
      addr_t    addr;
      logic     in_dccm, in_pic, external, misaligned, access_fault;
      mscause_t mscause;
      data_t    store_data;
      logic     single_ecc, double_ecc;   // Sampled while in M
   } stage_t;

   stage_t m, r;
   int     test_checks, test_errors;

   initial begin
      checks_total = 0;
      errors_total = 0;
      test_checks  = 0;
      test_errors  = 0;
   end

   // 1 DCCM, 2 PIC, 0 external
   function automatic int region_of(addr_t a);
      if (a >= DCCM_BASE && a < DCCM_BASE + DCCM_SIZE)
         return 1;
      if (a >= PIC_BASE && a < PIC_BASE + PIC_SIZE)
         return 2;
      return 0;
   endfunction

   //************************************************
   // Reference for the access leaving D
   //************************************************
   function automatic stage_t ref_d_stage();
      stage_t    s;
      dma_data_t lane;
      addr_t     last;
      s = '0;
      if (dec_lsu_valid_raw_d) begin          // Core wins whenever it asks
         s.valid      = ~flush_m_up;
         s.load       = lsu_load;
         s.store      = lsu_store;
         s.unsign     = lsu_unsign;
         s.size       = lsu_size;
         s.addr       = exu_lsu_rs1_d + addr_t'($signed(dec_lsu_offset_d));
         s.store_data = exu_lsu_rs2_d;
      end else if (dma_dccm_req) begin
         lane         = dma_mem_wdata >> (8 * dma_mem_addr[2:0]);
         s.valid      = 1'b1;
         s.dma        = 1'b1;
         s.load       = ~dma_mem_write;
         s.store      = dma_mem_write;
         s.size       = dma_mem_sz;
         s.addr       = dma_mem_addr;
         s.store_data = lane[31:0];
      end
      case (s.size)
         SIZE_HALF: last = s.addr + 32'd1;
         SIZE_WORD: last = s.addr + 32'd3;
         default:   last = s.addr;
      endcase
      s.in_dccm    = (region_of(s.addr) == 1);
      s.in_pic     = (region_of(s.addr) == 2);
      s.external   = (region_of(s.addr) == 0);
      s.misaligned = !s.in_dccm && ((s.size == SIZE_HALF && s.addr[0])
                                    || (s.size == SIZE_WORD && s.addr[1:0] != 2'b00));
      s.mscause    = MSCAUSE_NONE;
      if (s.misaligned) begin
         s.mscause = MSCAUSE_MISALIGNED;
      end else if (region_of(s.addr) != region_of(last)) begin
         s.access_fault = 1'b1;
         s.mscause      = MSCAUSE_REGION_CROSS;
      end else if (s.in_pic && s.size != SIZE_WORD) begin
         s.access_fault = 1'b1;
         s.mscause      = MSCAUSE_PIC_SIZE;
      end
      return s;
   endfunction

   function automatic data_t ref_load_result(stage_t s);
      data_t src;
      src = s.external ? bus_read_data_m : lsu_ld_data_m;
      case (s.size)
         SIZE_BYTE: return s.unsign ? data_t'(src[7:0]) : data_t'($signed(src[7:0]));
         SIZE_HALF: return s.unsign ? data_t'(src[15:0]) : data_t'($signed(src[15:0]));
         default:   return src;
      endcase
   endfunction

   task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
      checks_total++;
      if (got !== exp) begin
         errors_total++;
         $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   //************************************************
   // Compare, then advance the model
   //************************************************
   always @(posedge clk) begin
      logic exc_exp, err_exp, commit_exp, incr_exp;
      if (!arst_n) begin
         m = '0;
         r = '0;
      end else begin
         exc_exp = m.valid && (m.misaligned || m.access_fault);
         check_value("lsu_exc_m", lsu_exc_m, exc_exp);
         if (m.valid) begin
            check_value("lsu_addr_m", lsu_addr_m, m.addr);
            check_value("addr_in_dccm_m", addr_in_dccm_m, m.in_dccm);
            check_value("addr_in_pic_m", addr_in_pic_m, m.in_pic);
            check_value("addr_external_m", addr_external_m, m.external);
            check_value("store_data_m", store_data_m, m.store_data);
            if (m.load)
               check_value("lsu_result_m", lsu_result_m, ref_load_result(m));
         end

         err_exp    = (r.misaligned || r.access_fault || r.double_ecc) && r.valid && !r.dma;
         commit_exp = r.valid && (r.load || r.store) && !r.dma && !flush_r;
         incr_exp   = r.single_ecc && !r.double_ecc && (commit_exp || r.dma) && r.valid;
         check_value("lsu_error_valid_r", lsu_error_valid_r, err_exp);
         check_value("lsu_commit_r", lsu_commit_r, commit_exp);
         check_value("lsu_single_ecc_error_incr", lsu_single_ecc_error_incr, incr_exp);
         if (r.valid)
            check_value("lsu_addr_r", lsu_addr_r, r.addr);
         if (err_exp) begin
            check_value("lsu_error_type_r", lsu_error_type_r, !r.misaligned);
            check_value("lsu_error_store_r", lsu_error_store_r, r.store);
            check_value("lsu_error_mscause_r", lsu_error_mscause_r,
                        (r.misaligned || r.access_fault) ? r.mscause : MSCAUSE_ECC);
            check_value("lsu_error_addr_r", lsu_error_addr_r, r.addr);
         end

         if (test_end) begin
            $display("Test %0d finished: %0d checks, %0d errors", test_num,
                     checks_total - test_checks, errors_total - test_errors);
            test_checks = checks_total;
            test_errors = errors_total;
         end

         r            = m;
         r.valid      = m.valid && !(flush_m_up && !m.dma);   // Core entries flushed in M
         r.single_ecc = lsu_single_ecc_error_m;
         r.double_ecc = lsu_double_ecc_error_m;
         m            = ref_d_stage();
      end
   end

endmodule

/* testbench/tb_lsu_ctl.sv */
//************************************************
// LSU control testbench
// Clock, reset, random stimulus and watchdog
//************************************************
`timescale 1ns/1ps

module tb_lsu_ctl;
   import lsu_pkg::*;

   localparam int num_tests   = 6;
   localparam int test_cycles = 300;
   localparam int run_cycles  = 5 + num_tests * (test_cycles + 3) + 1;

   logic      clk, arst_n;
   logic      dec_lsu_valid_raw_d, lsu_load, lsu_store, lsu_unsign;
   size_t     lsu_size, dma_mem_sz;
   addr_t     exu_lsu_rs1_d, dma_mem_addr;
   offset_t   dec_lsu_offset_d;
   data_t     exu_lsu_rs2_d, lsu_ld_data_m, bus_read_data_m;
   logic      dma_dccm_req, dma_mem_write;
   dma_data_t dma_mem_wdata;
   logic      flush_m_up, flush_r, lsu_single_ecc_error_m, lsu_double_ecc_error_m;
   addr_t     lsu_addr_m, lsu_addr_r, lsu_error_addr_r;
   logic      addr_in_dccm_m, addr_in_pic_m, addr_external_m;
   data_t     store_data_m, lsu_result_m;
   logic      lsu_exc_m, lsu_commit_r, lsu_single_ecc_error_incr;
   logic      lsu_error_valid_r, lsu_error_type_r, lsu_error_store_r;
   mscause_t  lsu_error_mscause_r;
   int        seed = 32'h7873_a457;
   int        test_num, checks_total, errors_total;
   logic      test_end;

   lsu_ctl_top lsu_ctl_top_i (.*);

   lsu_checker lsu_checker_i (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      #((run_cycles + 20) * 100);
      $display("Timeout: the run did not end within %0d cycles", run_cycles + 20);
      $display("Errors found");
      $finish;
   end

   // Random address in DCCM, PIC or external space, or across a region edge
   function automatic addr_t pick_addr(logic near_edge);
      logic [31:0] sel, ofs;
      sel = $random(seed);
      ofs = $random(seed);
      if (near_edge) begin
         case (sel[1:0])
            2'd0:    return DCCM_BASE - 32'd4 + ofs[3:0];
            2'd1:    return DCCM_BASE + DCCM_SIZE - 32'd4 + ofs[3:0];
            2'd2:    return PIC_BASE - 32'd4 + ofs[3:0];
            default: return PIC_BASE + PIC_SIZE - 32'd4 + ofs[3:0];
         endcase
      end
      case (sel[1:0])
         2'd0:    return DCCM_BASE + {16'h0, ofs[15:0]};
         2'd1:    return PIC_BASE + {17'h0, ofs[14:0]};
         default: return ofs;
      endcase
   endfunction

   task automatic drive_idle();
      dec_lsu_valid_raw_d    <= 1'b0;
      lsu_load               <= 1'b0;
      lsu_store              <= 1'b0;
      lsu_unsign             <= 1'b0;
      lsu_size               <= SIZE_BYTE;
      exu_lsu_rs1_d          <= '0;
      dec_lsu_offset_d       <= '0;
      exu_lsu_rs2_d          <= '0;
      dma_dccm_req           <= 1'b0;
      dma_mem_write          <= 1'b0;
      dma_mem_sz             <= SIZE_BYTE;
      dma_mem_addr           <= '0;
      dma_mem_wdata          <= '0;
      flush_m_up             <= 1'b0;
      flush_r                <= 1'b0;
      lsu_single_ecc_error_m <= 1'b0;
      lsu_double_ecc_error_m <= 1'b0;
      lsu_ld_data_m          <= '0;
      bus_read_data_m        <= '0;
   endtask

   //************************************************
   // One random cycle, biased by the test number
   //************************************************
   task automatic drive_random(int test);
      logic [31:0] rnd, ctl;
      logic        near_edge;
      addr_t       target;
      offset_t     off;
      rnd       = $random(seed);
      ctl       = $random(seed);
      near_edge = (test == 3) ? rnd[3] : (rnd[7:3] == 5'd0);
      target    = pick_addr(near_edge);
      off       = rnd[31:20];
      dec_lsu_valid_raw_d <= rnd[0];
      lsu_load            <= rnd[8] & (rnd[16:15] != 2'b00);
      lsu_store           <= ~rnd[8] & (rnd[16:15] != 2'b00);   // Now and then neither
      lsu_unsign          <= rnd[9];
      lsu_size            <= size_t'(rnd[11:10] % 3);
      exu_lsu_rs1_d       <= target - {{20{off[11]}}, off};   // Lands on target
      dec_lsu_offset_d    <= off;
      exu_lsu_rs2_d       <= $random(seed);
      dma_dccm_req        <= rnd[1] | ((test == 4) & rnd[2]);   // Test 4 collides peers
      dma_mem_write       <= rnd[12];
      dma_mem_sz          <= size_t'(rnd[14:13] % 3);
      dma_mem_addr        <= pick_addr(near_edge);
      dma_mem_wdata       <= {$random(seed), $random(seed)};
      flush_m_up          <= (test == 5) ? (ctl[1:0] == 2'd0) : (ctl[5:0] == 6'd0);
      flush_r             <= (test == 5) ? (ctl[3:2] == 2'd0) : (ctl[11:6] == 6'd0);
      lsu_single_ecc_error_m <= (test == 6) ? (ctl[13:12] == 2'd0) : (ctl[17:12] == 6'd0);
      lsu_double_ecc_error_m <= (test == 6) ? (ctl[20:18] == 3'd0) : (ctl[25:20] == 6'd0);
      lsu_ld_data_m       <= $random(seed);
      bus_read_data_m     <= $random(seed);
   endtask

   initial begin
      arst_n   = 1'b0;
      test_end = 1'b0;
      test_num = 0;
      drive_idle();
      repeat (5) @(negedge clk);
      arst_n <= 1'b1;
      for (int t = 1; t <= num_tests; t++) begin
         test_num <= t;
         repeat (test_cycles) begin
            @(negedge clk);
            drive_random(t);
         end
         @(negedge clk);
         drive_idle();
         @(negedge clk);
         test_end <= 1'b1;    // Last access has reached R
         @(negedge clk);
         test_end <= 1'b0;
      end
      $display("%0d tests, %0d checks, %0d errors", num_tests, checks_total, errors_total);
      if (errors_total == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

/* sources.f */
verilog/lsu_pkg.sv
verilog/lsu_req_if.sv
verilog/lsu_core_req.sv
verilog/lsu_dma_req.sv
verilog/lsu_req_arbiter.sv
verilog/lsu_addr_check.sv
verilog/lsu_pipe.sv
verilog/lsu_load_align.sv
verilog/lsu_ctl_top.sv
testbench/lsu_checker.sv
testbench/tb_lsu_ctl.sv

/* run.sh */
#!/bin/sh
# Compile and run the LSU control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_lsu_ctl -f sources.f -o sim_lsu_ctl

./obj_dir/sim_lsu_ctl > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"
